/* logic/limb_config.svh */
`ifndef LIMB_CONFIG_SVH
`define LIMB_CONFIG_SVH

////////////////////////////////
// Fixed-point format
////////////////////////////////
`define LIMB_FRAC_BITS      16          // Q16.16
`define LIMB_DT_SHIFT       4           // Time step of 1/16

////////////////////////////////
// Waveform storage
////////////////////////////////
`define WAVE_DEPTH          64          // Torque samples held

// Values loaded by reset_global
`define HALF_CNT_DEFAULT    32'd3       // Tick every 4 cycles
`define DAMPING_DEFAULT     32'h0000_4000   // 0.25
`define STIFFNESS_DEFAULT   32'h0000_1000   // 0.0625

`endif

/* logic/host_if_pkg.sv */
package host_if_pkg;

    ////////////////////////////////
    // Host-side word formats
    ////////////////////////////////

    // Data wire and pipe word
    typedef logic [15:0] host_word_t;

    // One strobe bit per loadable register
    typedef logic [15:0] trig_vec_t;

    ////////////////////////////////
    // Trigger bit assignment
    ////////////////////////////////

    localparam int TRIG_HALF_CNT  = 7;     // Simulation rate divider
    localparam int TRIG_DAMPING   = 15;    // Joint damping
    localparam int TRIG_STIFFNESS = 14;    // Joint stiffness

    // Remaining bits are spare, strobes there are ignored

endpackage

/* logic/limb_types_pkg.sv */
package limb_types_pkg;

    ////////////////////////////////
    // Numeric format
    ////////////////////////////////

    // Signed Q16.16
    typedef logic signed [31:0] fixed_t;

    ////////////////////////////////
    // Model parameters
    ////////////////////////////////

    typedef struct packed {
        logic [31:0] half_cnt;      // Tick divider, period is half_cnt+1
        fixed_t      damping;
        fixed_t      stiffness;
    } limb_params_t;

    ////////////////////////////////
    // Joint state
    ////////////////////////////////

    // Torque used in the step travels along with the result
    typedef struct packed {
        fixed_t ext_trq;
        fixed_t pos;
        fixed_t vel;
        fixed_t acc;
    } limb_state_t;

endpackage

/* logic/param_bank.sv */
`timescale 1ns/1ps

`include "limb_config.svh"

module param_bank
    import host_if_pkg::*, limb_types_pkg::*;
(
    input  logic         ep50trig,
    input  logic         reset_global,
    input  trig_vec_t    trig_in,
    input  host_word_t   data_hi,
    input  host_word_t   data_lo,
    output limb_params_t params
);

    // Word presented by the host, high half first
    logic [31:0] load_word;

    assign load_word = {data_hi, data_lo};

    ////////////////////////////////
    // Model registers
    ////////////////////////////////

    // Several strobes at once load the same word into each
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            params.half_cnt  <= `HALF_CNT_DEFAULT;
            params.damping   <= `DAMPING_DEFAULT;
            params.stiffness <= `STIFFNESS_DEFAULT;
        end
        else
        begin
            if (trig_in[TRIG_HALF_CNT])
            begin
                params.half_cnt <= load_word;
            end
            if (trig_in[TRIG_DAMPING])
            begin
                params.damping <= load_word;    // Q16.16 as sent
            end
            if (trig_in[TRIG_STIFFNESS])
            begin
                params.stiffness <= load_word;
            end
        end
    end

endmodule

/* logic/sim_tick_gen.sv */
`timescale 1ns/1ps

`include "limb_config.svh"

module sim_tick_gen (
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic [31:0] half_cnt,
    output logic        sim_tick
);

    logic [31:0] cnt;
    logic [31:0] reload;

    // Zero would stall the divider, so clamp to one
    assign reload = (half_cnt == 32'd0) ? 32'd1 : half_cnt;

    // Down-counter, one pulse per reload+1 cycles
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            cnt      <= `HALF_CNT_DEFAULT;  // First tick a full period out
            sim_tick <= 1'b0;
        end
        else if (cnt == 32'd0)
        begin
            cnt      <= reload;     // New rate picked up here
            sim_tick <= 1'b1;
        end
        else
        begin
            cnt      <= cnt - 32'd1;
            sim_tick <= 1'b0;
        end
    end

endmodule

/* logic/waveform_buffer.sv */
`timescale 1ns/1ps

`include "limb_config.svh"

module waveform_buffer
    import host_if_pkg::*, limb_types_pkg::*;
(
    input  logic       ep50trig,
    input  logic       reset_global,
    input  logic       reset_sim,
    input  logic       pipe_write,
    input  host_word_t pipe_data,
    input  logic       sim_tick,
    output fixed_t     ext_trq,
    output logic       wave_ready
);

    localparam int PTR_W = $clog2(`WAVE_DEPTH);
    localparam logic [PTR_W:0] DEPTH_CNT = `WAVE_DEPTH;

    fixed_t           mem [`WAVE_DEPTH];
    host_word_t       lo_half;          // Low half waiting for its partner
    logic             have_lo;
    logic             pair_wr;
    logic             full;
    logic [PTR_W:0]   fill_cnt;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   rd_next;

    assign pair_wr = pipe_write && have_lo;
    assign full    = (fill_cnt == DEPTH_CNT);
    assign rd_next = {1'b0, rd_ptr} + 1'b1;

    ////////////////////////////////
    // Fill side
    ////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (pair_wr && !full)
        begin
            mem[fill_cnt[PTR_W-1:0]] <= {pipe_data, lo_half};
        end
    end

    always_ff @(posedge ep50trig)
    begin
        if (pipe_write && !have_lo)
        begin
            lo_half <= pipe_data;
        end
    end

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            have_lo    <= 1'b0;
            fill_cnt   <= '0;
            wave_ready <= 1'b0;
        end
        else if (pipe_write)
        begin
            have_lo <= !have_lo;
            if (pair_wr)
            begin
                wave_ready <= 1'b1;     // Sticky until global reset
                if (!full)
                begin
                    fill_cnt <= fill_cnt + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////
    // Playback side
    ////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            rd_ptr  <= '0;
            ext_trq <= '0;
        end
        else if (reset_sim)
        begin
            rd_ptr <= '0;   // Samples themselves stay
        end
        else if (sim_tick && wave_ready)
        begin
            ext_trq <= mem[rd_ptr];
            // Wrap at however many samples are loaded
            if (rd_next >= fill_cnt)
            begin
                rd_ptr <= '0;
            end
            else
            begin
                rd_ptr <= rd_next[PTR_W-1:0];
            end
        end
    end

endmodule

/* logic/limb_dynamics.sv */
`timescale 1ns/1ps

`include "limb_config.svh"

module limb_dynamics
    import limb_types_pkg::*;
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        reset_sim,
    input  logic        sim_tick,
    input  logic        wave_ready,
    input  fixed_t      ext_trq,
    input  fixed_t      damping,
    input  fixed_t      stiffness,
    output limb_state_t limb_out
);

    // Full-width products before rescaling
    logic signed [63:0] damp_prod;
    logic signed [63:0] stiff_prod;

    fixed_t damp_term;
    fixed_t stiff_term;
    fixed_t acc_next;
    fixed_t vel_next;
    fixed_t pos_next;

    ////////////////////////////////
    // One integration step
    ////////////////////////////////

    assign damp_prod  = damping * limb_out.vel;
    assign stiff_prod = stiffness * limb_out.pos;

    // Back to Q16.16, upper bits dropped
    assign damp_term  = damp_prod[`LIMB_FRAC_BITS +: 32];
    assign stiff_term = stiff_prod[`LIMB_FRAC_BITS +: 32];

    assign acc_next = ext_trq - damp_term - stiff_term;

    // Semi-implicit Euler, new acc feeds vel, new vel feeds pos
    assign vel_next = limb_out.vel + (acc_next >>> `LIMB_DT_SHIFT);
    assign pos_next = limb_out.pos + (vel_next >>> `LIMB_DT_SHIFT);

    ////////////////////////////////
    // State registers
    ////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || reset_sim)
        begin
            limb_out <= '0;
        end
        else if (sim_tick && wave_ready)
        begin
            limb_out.ext_trq <= ext_trq;    // Sample used for this step
            limb_out.acc     <= acc_next;
            limb_out.vel     <= vel_next;
            limb_out.pos     <= pos_next;
        end
    end

endmodule

/* logic/limb_core.sv */
`timescale 1ns/1ps

module limb_core
    import host_if_pkg::*, limb_types_pkg::*;
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        reset_sim,
    input  trig_vec_t   trig_in,
    input  host_word_t  data_hi,
    input  host_word_t  data_lo,
    input  logic        pipe_write,
    input  host_word_t  pipe_data,
    output logic        sim_tick,
    output logic        wave_ready,
    output limb_state_t limb_out
);

    limb_params_t params;
    fixed_t       ext_trq;

    // Host-loaded model parameters
    param_bank u_param_bank (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .trig_in      (trig_in),
        .data_hi      (data_hi),
        .data_lo      (data_lo),
        .params       (params)
    );

    // Simulation rate
    sim_tick_gen u_sim_tick_gen (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .half_cnt     (params.half_cnt),
        .sim_tick     (sim_tick)
    );

    ////////////////////////////////
    // Torque source and joint
    ////////////////////////////////

    waveform_buffer u_waveform_buffer (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .pipe_write   (pipe_write),
        .pipe_data    (pipe_data),
        .sim_tick     (sim_tick),
        .ext_trq      (ext_trq),
        .wave_ready   (wave_ready)
    );

    limb_dynamics u_limb_dynamics (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .sim_tick     (sim_tick),
        .wave_ready   (wave_ready),
        .ext_trq      (ext_trq),
        .damping      (params.damping),
        .stiffness    (params.stiffness),
        .limb_out     (limb_out)
    );

endmodule

/* verification/limb_core_assertions.sv */
`timescale 1ns/1ps

module limb_core_assertions
    import limb_types_pkg::*;
(
    input logic        ep50trig,
    input logic        reset_global,
    input logic        reset_sim,
    input logic        sim_tick,
    input logic        wave_ready,
    input limb_state_t limb_out
);

    int fail_cnt = 0;   // Violations so far, watched from the testbench

    ////////////////////////////////
    // Tick pulse shape
    ////////////////////////////////

    tick_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        sim_tick |=> !sim_tick)
    else
    begin
        $error("sim_tick was high on two cycles in a row");
        fail_cnt++;
    end

    ////////////////////////////////
    // Reset and playback
    ////////////////////////////////

    // Joint state cleared by either reset
    state_cleared: assert property (@(posedge ep50trig)
        (reset_global || reset_sim) |=> (limb_out == '0))
    else
    begin
        $error("limb_out not zero in the cycle after a reset");
        fail_cnt++;
    end

    ready_sticky: assert property (@(posedge ep50trig)
        (wave_ready && !reset_global) |=> wave_ready)
    else
    begin
        $error("wave_ready fell without reset_global");
        fail_cnt++;
    end

endmodule

bind limb_core limb_core_assertions u_assertions (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .reset_sim    (reset_sim),
    .sim_tick     (sim_tick),
    .wave_ready   (wave_ready),
    .limb_out     (limb_out)
);

/* verification/limb_core_tb.sv */
`timescale 1ns/1ps

`include "limb_config.svh"

module limb_core_tb
    import host_if_pkg::*, limb_types_pkg::*;
();

    logic        ep50trig;
    logic        reset_global;
    logic        reset_sim;
    trig_vec_t   trig_in;
    host_word_t  data_hi;
    host_word_t  data_lo;
    logic        pipe_write;
    host_word_t  pipe_data;
    logic        sim_tick;
    logic        wave_ready;
    limb_state_t limb_out;

    // Reference model state
    fixed_t      m_mem [`WAVE_DEPTH];
    int          m_fill;
    int          m_ptr;
    logic        m_have_lo;
    host_word_t  m_lo;
    logic        m_ready;
    fixed_t      m_trq;         // Torque held by the buffer output
    fixed_t      m_damp;
    fixed_t      m_stiff;
    limb_state_t m_state;
    logic        model_valid = 1'b0;

    fixed_t      samples [$];   // Write order
    logic [31:0] lcg_state;
    string       test_name;

    limb_core DUT (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .trig_in      (trig_in),
        .data_hi      (data_hi),
        .data_lo      (data_lo),
        .pipe_write   (pipe_write),
        .pipe_data    (pipe_data),
        .sim_tick     (sim_tick),
        .wave_ready   (wave_ready),
        .limb_out     (limb_out)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever
        begin
            #50 ep50trig = ~ep50trig;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic stop_with_failure();
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_equal(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected)
        else
        begin
            $display("ERR %s %s expected %0h actual %0h", test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    ////////////////////////////////
    // Host-side drivers
    ////////////////////////////////

    task automatic load_param(input int bit_idx, input logic [31:0] value);
        @(posedge ep50trig);
        trig_in <= 16'h0001 << bit_idx;
        data_hi <= value[31:16];
        data_lo <= value[15:0];
        @(posedge ep50trig);
        trig_in <= '0;
    endtask

    task automatic write_sample(input fixed_t sample);
        @(posedge ep50trig);
        pipe_write <= 1'b1;
        pipe_data  <= sample[15:0];     // Low half first
        @(posedge ep50trig);
        pipe_data  <= sample[31:16];
        @(posedge ep50trig);
        pipe_write <= 1'b0;
    endtask

    task automatic pulse_sim_reset();
        @(posedge ep50trig);
        reset_sim <= 1'b1;
        @(posedge ep50trig);
        reset_sim <= 1'b0;
    endtask

    // Returns at the falling edge of the next tick cycle
    task automatic wait_tick();
        int cycles;
        for (cycles = 0; cycles < 100; cycles++)
        begin
            @(negedge ep50trig);
            if (sim_tick)
            begin
                return;
            end
        end
        $display("Timeout: no sim_tick within 100 cycles in %s", test_name);
        stop_with_failure();
    endtask

    task automatic next_gap(output int gap);
        for (gap = 1; gap <= 100; gap++)
        begin
            @(negedge ep50trig);
            if (sim_tick)
            begin
                return;
            end
        end
        $display("Timeout: tick gap above 100 cycles in %s", test_name);
        stop_with_failure();
    endtask

    task automatic check_playback();
        int k;
        pulse_sim_reset();
        @(negedge ep50trig);
        check_equal("limb_out after reset_sim", '0, limb_out);
        if (!sim_tick)
        begin
            wait_tick();    // This step still uses the torque held before the rewind
        end
        for (k = 0; k <= 16; k++)
        begin
            wait_tick();
            @(negedge ep50trig);
            check_equal("ext_trq", $unsigned(samples[k % 16]), $unsigned(limb_out.ext_trq));
        end
    endtask

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    always @(negedge ep50trig)
    begin : reference_model
        logic signed [63:0] damp_prod;
        logic signed [63:0] stiff_prod;
        fixed_t acc;
        fixed_t vel;
        fixed_t pos;
        if (model_valid)
        begin
            check_equal("limb_out", m_state, limb_out);
            check_equal("wave_ready", m_ready, wave_ready);
        end
        if (reset_global)
        begin
            m_state     = '0;
            m_trq       = '0;
            m_ptr       = 0;
            m_fill      = 0;
            m_have_lo   = 1'b0;
            m_ready     = 1'b0;
            m_damp      = `DAMPING_DEFAULT;
            m_stiff     = `STIFFNESS_DEFAULT;
            model_valid = 1'b1;
        end
        else if (model_valid)
        begin
            if (reset_sim)
            begin
                m_state = '0;
                m_ptr   = 0;
            end
            else if (sim_tick && m_ready)
            begin
                vel        = m_state.vel;
                pos        = m_state.pos;
                damp_prod  = m_damp * vel;
                stiff_prod = m_stiff * pos;
                acc = m_trq - fixed_t'(damp_prod >>> `LIMB_FRAC_BITS)
                            - fixed_t'(stiff_prod >>> `LIMB_FRAC_BITS);
                vel = vel + (acc >>> `LIMB_DT_SHIFT);
                pos = pos + (vel >>> `LIMB_DT_SHIFT);
                m_state.ext_trq = m_trq;
                m_state.acc     = acc;
                m_state.vel     = vel;
                m_state.pos     = pos;
                m_trq = m_mem[m_ptr];       // Next sample, used at the following tick
                m_ptr = (m_ptr + 1 >= m_fill) ? 0 : m_ptr + 1;
            end
            if (pipe_write && m_have_lo)
            begin
                if (m_fill < `WAVE_DEPTH)
                begin
                    m_mem[m_fill] = {pipe_data, m_lo};
                    m_fill++;
                end
                m_ready = 1'b1;
            end
            else if (pipe_write)
            begin
                m_lo = pipe_data;
            end
            if (pipe_write)
            begin
                m_have_lo = !m_have_lo;
            end
            if (trig_in[TRIG_DAMPING])
            begin
                m_damp = {data_hi, data_lo};
            end
            if (trig_in[TRIG_STIFFNESS])
            begin
                m_stiff = {data_hi, data_lo};
            end
        end
    end

    // Stop at the first bound assertion failure
    always @(posedge ep50trig)
    begin
        if (DUT.u_assertions.fail_cnt != 0)
        begin
            $display("A bound assertion failed during %s", test_name);
            stop_with_failure();
        end
    end

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////

    initial
    begin : stimulus
        int     gap;
        int     k;
        fixed_t sample;
        reset_global = 1'b1;
        reset_sim    = 1'b0;
        trig_in      = '0;
        data_hi      = '0;
        data_lo      = '0;
        pipe_write   = 1'b0;
        pipe_data    = '0;
        lcg_state    = 32'd5009;

        test_name = "reset";
        repeat (10) @(posedge ep50trig);
        reset_global <= 1'b0;
        @(negedge ep50trig);
        check_equal("limb_out", '0, limb_out);
        check_equal("wave_ready", 1'b0, wave_ready);
        wait_tick();
        repeat (3)
        begin
            next_gap(gap);
            check_equal("tick gap", 4, gap);    // Default half_cnt of 3
        end

        test_name = "tick_clamp";
        load_param(TRIG_HALF_CNT, 32'd0);
        wait_tick();
        wait_tick();
        repeat (3)
        begin
            next_gap(gap);
            check_equal("tick gap", 2, gap);    // Zero runs as one
        end

        test_name = "tick_rate";
        load_param(TRIG_HALF_CNT, 32'd6);
        wait_tick();
        wait_tick();
        repeat (3)
        begin
            next_gap(gap);
            check_equal("tick gap", 7, gap);
        end

        test_name = "waveform";
        for (k = 0; k < 16; k++)
        begin
            lcg_state = lcg_next(lcg_state);
            sample = {{16{lcg_state[31]}}, lcg_state[31:16]};  // Within +-0.5
            samples.push_back(sample);
        end
        write_sample(samples[0]);
        @(negedge ep50trig);
        check_equal("wave_ready after first pair", 1'b1, wave_ready);
        for (k = 1; k < 16; k++)
        begin
            write_sample(samples[k]);
        end
        check_playback();

        test_name = "dynamics";
        load_param(TRIG_DAMPING, 32'h0000_8000);     // 0.5
        load_param(TRIG_STIFFNESS, 32'h0000_2000);   // 0.125
        repeat (24) wait_tick();

        test_name = "sim_reset";
        repeat (5) wait_tick();
        check_playback();
        repeat (8) wait_tick();     // Loaded parameters still in use
        repeat (2)
        begin
            next_gap(gap);
            check_equal("tick gap", 7, gap);    // Rate kept through reset_sim
        end

        repeat (2) @(negedge ep50trig);
        if (DUT.u_assertions.fail_cnt != 0)
        begin
            $display("A bound assertion failed before the end of the run");
            stop_with_failure();
        end
        else
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

/* verilog.f */
+incdir+logic
logic/host_if_pkg.sv
logic/limb_types_pkg.sv
logic/param_bank.sv
logic/sim_tick_gen.sv
logic/waveform_buffer.sv
logic/limb_dynamics.sv
logic/limb_core.sv
verification/limb_core_assertions.sv
verification/limb_core_tb.sv
